//--- conv_settings.svh
// Sizing macros for the convolution engine, pulled in by the packages and RTL files.
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// ------------------------------
// window geometry
// ------------------------------
`define CONV_ROWS       7
`define CONV_COLS       5
`define CONV_TAPS       (`CONV_ROWS * `CONV_COLS)

// ------------------------------
// datapath widths
// ------------------------------
`define SAMPLE_WIDTH    40
`define COEF_WIDTH      33
`define PRODUCT_WIDTH   (`SAMPLE_WIDTH + `COEF_WIDTH)
`define ACC_WIDTH       80      // room for 35 products plus carries.
`define ROUND_SHIFT     25
`define RESULT_WIDTH    45

`define FIFO_DEPTH      8       // output buffer entries.

`endif

//--- source/conv_data_pkg.sv
// Value types of the convolution datapath, imported by every RTL block and the checker.
`include "conv_settings.svh"

package conv_data_pkg;

    // scalar values, all two's complement.
    typedef logic signed [`SAMPLE_WIDTH-1:0]  sample_t;
    typedef logic signed [`COEF_WIDTH-1:0]    coef_t;
    typedef logic signed [`PRODUCT_WIDTH-1:0] product_t;
    typedef logic signed [`ACC_WIDTH-1:0]     acc_t;
    typedef logic signed [`RESULT_WIDTH-1:0]  result_t;

    // ------------------------------
    // whole-window bundles
    // ------------------------------
    // tap index is row * CONV_COLS + column.
    typedef sample_t  [`CONV_TAPS-1:0] sample_window_t;
    typedef coef_t    [`CONV_TAPS-1:0] coef_set_t;
    typedef product_t [`CONV_TAPS-1:0] product_set_t;

endpackage

//--- source/conv_ctrl_pkg.sv
// Address and pointer types for coefficient writes and the output FIFO.
`include "conv_settings.svh"

package conv_ctrl_pkg;

    // addresses past the last tap are ignored.
    typedef logic [$clog2(`CONV_TAPS)-1:0] tap_addr_t;

    typedef logic [$clog2(`FIFO_DEPTH)-1:0] fifo_ptr_t;

endpackage

//--- source/coef_bank.sv
// Coefficient store for the convolution taps, loaded one tap per write strobe on ca/cd/cw.
`timescale 1ns/10ps
`include "conv_settings.svh"

module coef_bank (
    input  logic                     clk,
    input  logic                     reset,
    input  conv_ctrl_pkg::tap_addr_t ca,
    input  conv_data_pkg::coef_t     cd,
    input  logic                     cw,
    output conv_data_pkg::coef_set_t coefs
);
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;

    logic [`CONV_TAPS-1:0] tap_sel;   // one-hot write decode.

    for (genvar t = 0; t < `CONV_TAPS; t++) begin : g_tap
        coef_t coef_q;

        // out of range addresses match no tap.
        assign tap_sel[t] = cw && (ca == tap_addr_t'(t));

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                coef_q <= '0;
            end else if (tap_sel[t]) begin
                coef_q <= cd;
            end
        end

        assign coefs[t] = coef_q;
    end

endmodule

//--- source/product_pipeline.sv
// Captures each sample window and multiplies all taps by their coefficients in three stages.
`timescale 1ns/10ps
`include "conv_settings.svh"

module product_pipeline (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          push_samp,
    input  conv_data_pkg::sample_window_t samp,
    input  conv_data_pkg::coef_set_t      coefs,
    output conv_data_pkg::product_set_t   products,
    output logic                          prod_valid
);
    import conv_data_pkg::*;

    // sample is split in two halves, low half treated as unsigned.
    localparam int HALF     = `SAMPLE_WIDTH / 2;
    localparam int LO_WIDTH = `COEF_WIDTH + HALF + 1;
    localparam int HI_WIDTH = `COEF_WIDTH + `SAMPLE_WIDTH - HALF;

    sample_window_t samp_q;
    logic           push_q;
    logic           valid_s1;
    logic           valid_s2;

    // ------------------------------
    // input capture
    // ------------------------------
    always_ff @(posedge clk) begin
        samp_q <= samp;   // every cycle, push_q says if it counts.
    end

    // ------------------------------
    // valid chain
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            push_q     <= 1'b0;
            valid_s1   <= 1'b0;
            valid_s2   <= 1'b0;
            prod_valid <= 1'b0;
        end else begin
            push_q     <= push_samp;
            valid_s1   <= push_q;
            valid_s2   <= valid_s1;
            prod_valid <= valid_s2;
        end
    end

    // ------------------------------
    // per-tap multipliers
    // ------------------------------
    for (genvar t = 0; t < `CONV_TAPS; t++) begin : g_tap
        coef_t                      coef;
        sample_t                    sample;
        logic signed [LO_WIDTH-1:0] part_lo;
        logic signed [HI_WIDTH-1:0] part_hi;
        product_t                   prod_sum;
        product_t                   prod_q;

        assign coef   = coefs[t];
        assign sample = samp_q[t];

        always_ff @(posedge clk) begin
            // stage 1 partial products.
            part_lo  <= coef * $signed({1'b0, sample[HALF-1:0]});
            part_hi  <= coef * $signed(sample[`SAMPLE_WIDTH-1:HALF]);
            // stage 2 aligns the high half and adds.
            prod_sum <= (product_t'(part_hi) <<< HALF) + product_t'(part_lo);
            prod_q   <= prod_sum;   // stage 3.
        end

        assign products[t] = prod_q;
    end

endmodule

//--- source/sum_round_stage.sv
// Adds all tap products and rounds the sum down to the result width with a valid bit.
`timescale 1ns/10ps
`include "conv_settings.svh"

module sum_round_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  conv_data_pkg::product_set_t products,
    input  logic                        prod_valid,
    output conv_data_pkg::result_t      result,
    output logic                        result_valid
);
    import conv_data_pkg::*;

    // half an lsb, added to negative sums only.
    localparam acc_t ROUND_BIAS = acc_t'(1) <<< (`ROUND_SHIFT - 1);

    acc_t sum_d;
    acc_t sum_q;
    acc_t biased;
    acc_t rounded;
    logic sum_valid;

    // ------------------------------
    // product sum
    // ------------------------------
    always_comb begin
        sum_d = '0;
        for (int t = 0; t < `CONV_TAPS; t++) begin
            sum_d = sum_d + acc_t'(products[t]);   // sign extended.
        end
    end

    // ------------------------------
    // rounding
    // ------------------------------
    always_comb begin
        biased = sum_q;
        if (sum_q < 0) begin
            biased = sum_q + ROUND_BIAS;
        end
    end

    assign rounded = biased >>> `ROUND_SHIFT;

    always_ff @(posedge clk) begin
        sum_q  <= sum_d;
        result <= rounded[`RESULT_WIDTH-1:0];   // upper bits dropped.
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum_valid    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            sum_valid    <= prod_valid;
            result_valid <= sum_valid;
        end
    end

endmodule

//--- source/result_fifo.sv
// Output buffer for results, presented to the consumer over the pushout/stopout handshake.
`timescale 1ns/10ps
`include "conv_settings.svh"

module result_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic                   clk,
    input  logic                   reset,
    input  conv_data_pkg::result_t result,
    input  logic                   result_valid,
    input  logic                   stopout,
    output logic                   pushout,
    output conv_data_pkg::result_t res
);
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;

    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    result_t                mem [DEPTH];
    fifo_ptr_t              wr_ptr;
    fifo_ptr_t              rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   full;
    logic                   wr_en;
    logic                   rd_en;

    function automatic fifo_ptr_t next_ptr(input fifo_ptr_t ptr);
        if (ptr == fifo_ptr_t'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = (count == COUNT_WIDTH'(DEPTH));
    assign pushout = (count != '0);
    assign wr_en   = result_valid && !full;    // overflow is dropped.
    assign rd_en   = pushout && !stopout;
    assign res     = mem[rd_ptr];

    // ------------------------------
    // storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= result;
        end
    end

    // ------------------------------
    // pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= next_ptr(wr_ptr);
            if (rd_en) rd_ptr <= next_ptr(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle, or read and write together.
            endcase
        end
    end

endmodule

//--- source/conv_top.sv
// Top of the 7x5 convolution engine; connects coefficient bank, multipliers, adder and FIFO.
`timescale 1ns/10ps

module conv_top (
    input  logic                          clk,
    input  logic                          reset,
    // coefficient write port.
    input  conv_ctrl_pkg::tap_addr_t      ca,
    input  conv_data_pkg::coef_t          cd,
    input  logic                          cw,
    // sample push.
    input  logic                          push_samp,
    input  conv_data_pkg::sample_window_t samp,
    // result handshake.
    input  logic                          stopout,
    output logic                          pushout,
    output conv_data_pkg::result_t        res
);
    import conv_data_pkg::*;

    coef_set_t    coefs;
    product_set_t products;
    logic         prod_valid;
    result_t      result;
    logic         result_valid;

    // ------------------------------
    // datapath
    // ------------------------------
    coef_bank coef_bank_inst (
        .clk   (clk),
        .reset (reset),
        .ca    (ca),
        .cd    (cd),
        .cw    (cw),
        .coefs (coefs)
    );

    product_pipeline product_pipeline_inst (
        .clk        (clk),
        .reset      (reset),
        .push_samp  (push_samp),
        .samp       (samp),
        .coefs      (coefs),
        .products   (products),
        .prod_valid (prod_valid)
    );

    sum_round_stage sum_round_stage_inst (
        .clk          (clk),
        .reset        (reset),
        .products     (products),
        .prod_valid   (prod_valid),
        .result       (result),
        .result_valid (result_valid)
    );

    // ------------------------------
    // output buffer
    // ------------------------------
    result_fifo result_fifo_inst (
        .clk          (clk),
        .reset        (reset),
        .result       (result),
        .result_valid (result_valid),
        .stopout      (stopout),
        .pushout      (pushout),
        .res          (res)
    );

endmodule

//--- tests/conv_checker.sv
// Scoreboard for the convolution engine; shadows coefficients, models the FIFO and checks res.
`timescale 1ns/10ps
`include "conv_settings.svh"

module conv_checker (
    input  logic                          clk,
    input  logic                          reset,
    input  conv_ctrl_pkg::tap_addr_t      ca,
    input  conv_data_pkg::coef_t          cd,
    input  logic                          cw,
    input  logic                          push_samp,
    input  conv_data_pkg::sample_window_t samp,
    input  logic                          stopout,
    input  logic                          pushout,
    input  conv_data_pkg::result_t        res,
    output int                            err_count,
    output int                            xfer_count,
    output int                            drop_count,
    output logic                          idle
);
    import conv_data_pkg::*;

    localparam int LATENCY = 6;   // push edge to fifo write edge.

    coef_t              shadow [`CONV_TAPS];
    result_t            expq [$];
    logic [LATENCY-1:0] fly_valid;
    result_t            fly_res [LATENCY];
    int                 pre_size;
    logic               exp_valid;

    // exact sum biased by half an lsb when negative and shifted right.
    function automatic result_t expected_result(input sample_window_t w);
        acc_t s;
        s = '0;
        for (int t = 0; t < `CONV_TAPS; t++) begin
            s = s + acc_t'(shadow[t]) * acc_t'(w[t]);
        end
        if (s < 0) begin
            s = s + (acc_t'(1) << (`ROUND_SHIFT - 1));
        end
        s = s >>> `ROUND_SHIFT;
        return s[`RESULT_WIDTH-1:0];
    endfunction

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int t = 0; t < `CONV_TAPS; t++) shadow[t] = '0;
            expq.delete();
            fly_valid  = '0;
            err_count  = 0;
            xfer_count = 0;
            drop_count = 0;
            idle       = 1'b1;
        end else begin
            // ------------------------------
            // output side
            // ------------------------------
            pre_size  = expq.size();
            exp_valid = (pre_size != 0);
            if (pushout !== exp_valid) begin
                $display("Mismatch at %0t: pushout expected %0b, actual %0b",
                         $time, exp_valid, pushout);
                err_count++;
            end
            if (exp_valid && pushout === 1'b1 && res !== expq[0]) begin
                $display("Mismatch at %0t: res expected %h, actual %h", $time, expq[0], res);
                err_count++;
            end
            if (pushout === 1'b1 && !stopout) begin
                xfer_count++;   // transfers the DUT actually made.
            end
            if (exp_valid && !stopout) begin
                void'(expq.pop_front());
            end
            // full is judged before this edge's read.
            if (fly_valid[LATENCY-1]) begin
                if (pre_size < `FIFO_DEPTH) expq.push_back(fly_res[LATENCY-1]);
                else drop_count++;
            end

            // ------------------------------
            // input side
            // ------------------------------
            if (cw && ca < `CONV_TAPS) begin
                shadow[ca] = cd;   // same-edge write counts for this push.
            end
            for (int i = LATENCY - 1; i > 0; i--) fly_res[i] = fly_res[i-1];
            fly_valid  = {fly_valid[LATENCY-2:0], push_samp};
            fly_res[0] = push_samp ? expected_result(samp) : '0;
            idle       = (expq.size() == 0) && (fly_valid == '0);
        end
    end

endmodule

//--- tests/conv_tb.sv
// Testbench for conv_top; runs the tests listed in the cases file and reports the final status.
`timescale 1ns/10ps
`include "conv_settings.svh"

module conv_tb;
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;

    localparam int MAX_TESTS = 64;
    localparam int HOLD_TAIL = 8;   // cycles stopout stays high after the last push.

    logic           clk;
    logic           reset;
    tap_addr_t      ca;
    coef_t          cd;
    logic           cw;
    logic           push_samp;
    sample_window_t samp;
    logic           stopout;
    logic           pushout;
    result_t        res;
    int             err_count;
    int             xfer_count;
    int             drop_count;
    logic           idle;

    integer         seed;
    logic [127:0]   kind_tab [MAX_TESTS];
    logic [127:0]   coef_tab [MAX_TESTS];
    logic [127:0]   stop_tab [MAX_TESTS];
    int             push_tab [MAX_TESTS];
    int             tap_tab  [MAX_TESTS];
    int             num_tests;
    int             total_pushes;
    int             failed_tests;
    logic           cases_loaded;
    logic           load_error;

    always #10 clk = ~clk;

    conv_top conv_top_inst (
        .clk(clk), .reset(reset), .ca(ca), .cd(cd), .cw(cw), .push_samp(push_samp),
        .samp(samp), .stopout(stopout), .pushout(pushout), .res(res)
    );

    conv_checker conv_checker_inst (
        .clk(clk), .reset(reset), .ca(ca), .cd(cd), .cw(cw), .push_samp(push_samp),
        .samp(samp), .stopout(stopout), .pushout(pushout), .res(res),
        .err_count(err_count), .xfer_count(xfer_count), .drop_count(drop_count), .idle(idle)
    );

    task automatic read_cases();
        integer           fd;
        integer           r;
        logic [8*160-1:0] line;
        logic [127:0]     kind;
        logic [127:0]     cmode;
        logic [127:0]     smode;
        int               n;
        int               tap;
        fd = $fopen("tests/conv_cases.txt", "r");
        if (fd == 0) begin
            $display("Error: the cases file tests/conv_cases.txt could not be opened");
            load_error = 1'b1;
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                line = '0;
                r = $fgets(line, fd);
                r = $sscanf(line, "%s %d %s %d %s", kind, n, cmode, tap, smode);
                if (r == 5) begin   // comments and blank lines fall through.
                    kind_tab[num_tests] = kind;
                    push_tab[num_tests] = n;
                    coef_tab[num_tests] = cmode;
                    tap_tab[num_tests]  = tap;
                    stop_tab[num_tests] = smode;
                    total_pushes += n;
                    num_tests++;
                end
            end
            $fclose(fd);
        end
        cases_loaded = 1'b1;
    endtask

    function automatic coef_t random_coef();
        return coef_t'({$random(seed), $random(seed)});
    endfunction

    function automatic sample_window_t random_window();
        sample_window_t w;
        for (int t = 0; t < `CONV_TAPS; t++) w[t] = sample_t'({$random(seed), $random(seed)});
        return w;
    endfunction

    task automatic load_coefs(input logic [127:0] mode, input int tap);
        for (int t = 0; t < `CONV_TAPS; t++) begin
            @(negedge clk);
            ca = tap_addr_t'(t);
            cw = 1'b1;
            if (mode == "zero") cd = '0;
            else if (mode == "single") cd = (t == tap) ? (coef_t'(1) << `ROUND_SHIFT) : '0;
            else cd = random_coef();
        end
        @(negedge clk);
        cw = 1'b0;
    endtask

    // ------------------------------
    // one test from the table
    // ------------------------------
    task automatic run_test(input int idx);
        int   n;
        int   pushed;
        int   tap;
        int   err0;
        int   xfer0;
        int   drop0;
        int   exp_drop;
        int   errs;
        int   xfers;
        int   drops;
        logic hold_mode;
        logic rand_stop;
        logic rewrites;
        logic do_push;
        logic ok;
        n         = push_tab[idx];
        hold_mode = (stop_tab[idx] == "hold");
        rand_stop = (stop_tab[idx] == "random");
        rewrites  = (kind_tab[idx] == "rewrite");
        tap       = (tap_tab[idx] < 0) ? int'({$random(seed)} % `CONV_TAPS) : tap_tab[idx];
        err0      = err_count;
        xfer0     = xfer_count;
        drop0     = drop_count;
        load_coefs(coef_tab[idx], tap);
        pushed = 0;
        while (pushed < n) begin
            @(negedge clk);
            cw      = 1'b0;
            stopout = hold_mode ? 1'b1 : (rand_stop ? (($random(seed) & 1) == 1) : 1'b0);
            if (rand_stop) do_push = (($random(seed) & 3) == 0);   // slow enough to never fill.
            else if (rewrites) do_push = (($random(seed) & 1) == 1);
            else do_push = 1'b1;
            if (rewrites && (($random(seed) & 1) == 1)) begin
                ca = tap_addr_t'($random(seed));   // includes addresses past the bank.
                cd = random_coef();
                cw = 1'b1;
            end
            push_samp = do_push;
            if (do_push) begin
                samp = random_window();
                pushed++;
            end
        end
        @(negedge clk);
        push_samp = 1'b0;
        cw        = 1'b0;
        if (hold_mode) repeat (HOLD_TAIL) @(negedge clk);
        if (n == 0) repeat (20) @(negedge clk);
        while (!idle) begin
            stopout = rand_stop ? (($random(seed) & 1) == 1) : 1'b0;
            @(negedge clk);
        end
        stopout  = 1'b0;
        exp_drop = (hold_mode && n > `FIFO_DEPTH) ? n - `FIFO_DEPTH : 0;
        errs     = err_count - err0;
        xfers    = xfer_count - xfer0;
        drops    = drop_count - drop0;
        ok       = (errs == 0) && (drops == exp_drop) && (xfers == n - exp_drop);
        if (drops != exp_drop) begin
            $display("Error: test %0d lost %0d results where %0d were expected to be lost",
                     idx, drops, exp_drop);
        end
        if (!ok) failed_tests++;
        $display("test %0d %0s: %0d pushes, %0d results, %0d dropped, %0d errors, %0s",
                 idx, kind_tab[idx], n, xfers, drops, errs, ok ? "ok" : "failed");
    endtask

    initial begin
        int limit;
        wait (cases_loaded);
        limit = total_pushes * 40 + 2000;
        repeat (limit) @(posedge clk);
        $display("Error: the run timed out after %0d cycles", limit);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        ca           = '0;
        cd           = '0;
        cw           = 1'b0;
        push_samp    = 1'b0;
        samp         = '0;
        stopout      = 1'b0;
        seed         = 32'hf8cdd09e;
        num_tests    = 0;
        total_pushes = 0;
        failed_tests = 0;
        load_error   = 1'b0;
        cases_loaded = 1'b0;
        read_cases();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < num_tests; i++) run_test(i);
        $display("tests run %0d, failed %0d, mismatches %0d, results checked %0d, dropped %0d",
                 num_tests, failed_tests, err_count, xfer_count, drop_count);
        if (!load_error && num_tests > 0 && failed_tests == 0 && err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/conv_cases.txt
# kind  pushes  coef_mode  tap  stop_mode
# tap is the single-tap index, -1 picks one at random; stop_mode is never, random or hold
idle      0   zero    -1  never
zero     10   zero    -1  never
single   12   single   0  never
single   12   single  34  never
single   12   single  -1  never
single   12   single  -1  never
random   16   random  -1  never
random   40   random  -1  never
rewrite  30   random  -1  never
rewrite  24   random  -1  random
stoprand 40   random  -1  random
stoprand 40   random  -1  random
stophold 12   random  -1  hold
stophold 12   single  -1  hold
stoprand 20   single  -1  random
random   24   zero    -1  random
random   20   random  -1  never

//--- filelist.f
+incdir+.
source/conv_data_pkg.sv
source/conv_ctrl_pkg.sv
source/coef_bank.sv
source/product_pipeline.sv
source/sum_round_stage.sv
source/result_fifo.sv
source/conv_top.sv
tests/conv_checker.sv
tests/conv_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the convolution testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f filelist.f \
    --top-module conv_tb \
    -o conv_sim

./obj_dir/conv_sim | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
